/* design/emesh_pkg.sv */
// Emesh packet types
package emesh_pkg;

   // Field widths of one Emesh transaction
   // Destination and source addresses
   typedef logic [31:0] emesh_addr_t;

   // Payload word
   typedef logic [31:0] emesh_data_t;

   // Transfer size, byte to double word
   typedef logic [1:0]  emesh_datamode_t;

   // Side-band control bits
   typedef logic [3:0]  emesh_ctrlmode_t;

   // Stored FIFO word, 103 bits
   // Access is not stored
   // An occupied entry already means a valid packet
   typedef struct packed {
      // Top of the word
      emesh_addr_t     srcaddr;
      emesh_data_t     data;
      emesh_addr_t     dstaddr;
      emesh_ctrlmode_t ctrlmode;
      emesh_datamode_t datamode;
      // Bit zero
      logic            write;
   } emesh_packet_t;

   // FIFO sizing defaults
   // Address width 5 gives 32 entries
   localparam int FIFO_AW_DEFAULT   = 5;

   // Occupancy that raises programmable full
   localparam int PROG_FULL_DEFAULT = 24;

endpackage

/* design/fifo_mem.sv */
// Dual clock packet storage
module fifo_mem #(
   parameter int AW = emesh_pkg::FIFO_AW_DEFAULT
) (
   input  logic                     wr_clk,
   // Write port, wr_clk domain
   input  logic                     we,
   input  logic [AW-1:0]            waddr,
   input  emesh_pkg::emesh_packet_t wdata,
   // Read port, address from rd_clk domain
   input  logic [AW-1:0]            raddr,
   output emesh_pkg::emesh_packet_t rdata
);

   // One packet per entry
   emesh_pkg::emesh_packet_t mem [2**AW];

   // Write on the accepting wr_clk edge
   always_ff @(posedge wr_clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Asynchronous read
   // Head entry always sits on rdata
   assign rdata = mem[raddr];

endmodule

/* design/fifo_wr_ctrl.sv */
// FIFO write pointer control
module fifo_wr_ctrl #(
   parameter int AW              = emesh_pkg::FIFO_AW_DEFAULT,
   parameter int PROG_FULL_LEVEL = emesh_pkg::PROG_FULL_DEFAULT
) (
   input  logic          wr_clk,
   input  logic          rst_n,
   input  logic          wr_en,
   // Read gray pointer, already in this domain
   input  logic [AW:0]   rd_gray_sync,
   // Gray pointer toward the read domain
   output logic [AW:0]   wr_gray,
   output logic          mem_we,
   output logic [AW-1:0] mem_waddr,
   output logic          full,
   output logic          prog_full
);

   // Pointer with wrap bit on top
   typedef logic [AW:0] ptr_t;

   // Entry count of a full array
   localparam ptr_t DEPTH     = ptr_t'(2 ** AW);
   localparam ptr_t PROG_FULL = ptr_t'(PROG_FULL_LEVEL);

   logic [1:0] rst_pipe;
   logic       wr_rst_n;
   ptr_t       wr_bin;
   ptr_t       wr_bin_next;
   ptr_t       rd_bin_sync;
   ptr_t       occupancy_next;

   // Gray to binary, MSB first
   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[AW] = gray[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         bin[i] = bin[i + 1] ^ gray[i];
      end
      return bin;
   endfunction

   // Reset re-timed to wr_clk
   always_ff @(posedge wr_clk) begin
      rst_pipe <= {rst_pipe[0], rst_n};
   end
   assign wr_rst_n = rst_pipe[1];

   // Writes while full are dropped here
   assign mem_we      = wr_en && !full;
   assign mem_waddr   = wr_bin[AW-1:0];
   assign wr_bin_next = wr_bin + ptr_t'(mem_we);

   // Stale read pointer, so count never under-reports
   assign rd_bin_sync    = gray2bin(rd_gray_sync);
   assign occupancy_next = wr_bin_next - rd_bin_sync;

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin    <= '0;
         wr_gray   <= '0;
         full      <= 1'b0;
         prog_full <= 1'b0;
      end else begin
         wr_bin    <= wr_bin_next;
         // Registered gray, glitch free into the crossing
         wr_gray   <= wr_bin_next ^ (wr_bin_next >> 1);
         full      <= (occupancy_next == DEPTH);
         prog_full <= (occupancy_next >= PROG_FULL);
      end
   end

   // Array never overwritten once it holds every entry
   a_no_write_at_depth : assert property (
      @(posedge wr_clk) disable iff (wr_rst_n !== 1'b1)
         ((wr_bin - rd_bin_sync) == DEPTH) |-> !mem_we
   ) else $error("fifo_wr_ctrl: write accepted with array at depth");

   // One bit step per cycle, safe for the crossing
   a_gray_one_step : assert property (
      @(posedge wr_clk) disable iff (wr_rst_n !== 1'b1)
         $countones(wr_gray ^ $past(wr_gray)) <= 1
   ) else $error("fifo_wr_ctrl: write gray pointer moved by more than one bit");

endmodule

/* design/fifo_rd_ctrl.sv */
// FIFO read pointer control
module fifo_rd_ctrl #(
   parameter int AW = emesh_pkg::FIFO_AW_DEFAULT
) (
   input  logic          rd_clk,
   input  logic          rst_n,
   input  logic          rd_en,
   // Write gray pointer, already in this domain
   input  logic [AW:0]   wr_gray_sync,
   // Gray pointer toward the write domain
   output logic [AW:0]   rd_gray,
   output logic [AW-1:0] mem_raddr,
   output logic          empty
);

   // Pointer with wrap bit on top
   typedef logic [AW:0] ptr_t;

   logic [1:0] rst_pipe;
   logic       rd_rst_n;
   logic       rd_accept;
   ptr_t       rd_bin;
   ptr_t       rd_bin_next;
   ptr_t       rd_gray_next;

   // Reset re-timed to rd_clk
   always_ff @(posedge rd_clk) begin
      rst_pipe <= {rst_pipe[0], rst_n};
   end
   assign rd_rst_n = rst_pipe[1];

   // Pop only real entries
   assign rd_accept    = rd_en && !empty;
   assign rd_bin_next  = rd_bin + ptr_t'(rd_accept);
   assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

   // Head entry address
   assign mem_raddr = rd_bin[AW-1:0];

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
         empty   <= 1'b1;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_gray_next;
         // Equal gray pointers, nothing left
         // Set on the edge of the last pop
         empty   <= (rd_gray_next == wr_gray_sync);
      end
   end

   // Pop only while trailing the synchronized write pointer
   a_no_pop_when_empty : assert property (
      @(posedge rd_clk) disable iff (rd_rst_n !== 1'b1)
         rd_accept |-> (rd_gray != wr_gray_sync)
   ) else $error("fifo_rd_ctrl: read pointer advanced while empty");

endmodule

/* design/fifo_async.sv */
// Asynchronous FIFO core
module fifo_async #(
   parameter int AW              = emesh_pkg::FIFO_AW_DEFAULT,
   parameter int PROG_FULL_LEVEL = emesh_pkg::PROG_FULL_DEFAULT
) (
   input  logic                     wr_clk,
   input  logic                     rd_clk,
   input  logic                     rst_n,
   // Write domain
   input  logic                     wr_en,
   input  emesh_pkg::emesh_packet_t wr_data,
   output logic                     full,
   output logic                     prog_full,
   // Read domain
   input  logic                     rd_en,
   output emesh_pkg::emesh_packet_t rd_data,
   output logic                     empty
);

   logic [AW:0]   wr_gray;
   logic [AW:0]   rd_gray;
   logic [AW:0]   wr_gray_meta;
   logic [AW:0]   wr_gray_sync;
   logic [AW:0]   rd_gray_meta;
   logic [AW:0]   rd_gray_sync;
   logic          mem_we;
   logic [AW-1:0] mem_waddr;
   logic [AW-1:0] mem_raddr;

   // Write pointer into rd_clk, two flops
   always_ff @(posedge rd_clk) begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
   end

   // Read pointer into wr_clk, two flops
   always_ff @(posedge wr_clk) begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
   end

   fifo_wr_ctrl #(
      .AW              (AW),
      .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
   ) u_wr_ctrl (
      .wr_clk       (wr_clk),
      .rst_n        (rst_n),
      .wr_en        (wr_en),
      .rd_gray_sync (rd_gray_sync),
      .wr_gray      (wr_gray),
      .mem_we       (mem_we),
      .mem_waddr    (mem_waddr),
      .full         (full),
      .prog_full    (prog_full)
   );

   fifo_rd_ctrl #(
      .AW (AW)
   ) u_rd_ctrl (
      .rd_clk       (rd_clk),
      .rst_n        (rst_n),
      .rd_en        (rd_en),
      .wr_gray_sync (wr_gray_sync),
      .rd_gray      (rd_gray),
      .mem_raddr    (mem_raddr),
      .empty        (empty)
   );

   fifo_mem #(
      .AW (AW)
   ) u_mem (
      .wr_clk (wr_clk),
      .we     (mem_we),
      .waddr  (mem_waddr),
      .wdata  (wr_data),
      .raddr  (mem_raddr),
      .rdata  (rd_data)
   );

   // Entry written before the read side could see it
   a_head_known : assert property (
      @(posedge rd_clk) disable iff (rst_n !== 1'b1)
         !empty |-> !$isunknown(rd_data)
   ) else $error("fifo_async: head entry unknown while not empty");

endmodule

/* design/fifo_async_emesh.sv */
// Emesh packet clock crossing
module fifo_async_emesh #(
   parameter int AW              = emesh_pkg::FIFO_AW_DEFAULT,
   parameter int PROG_FULL_LEVEL = emesh_pkg::PROG_FULL_DEFAULT
) (
   input  logic                       wr_clk,
   input  logic                       rd_clk,
   input  logic                       rst_n,
   // Incoming packet, wr_clk domain
   input  logic                       emesh_access_in,
   input  logic                       emesh_write_in,
   input  emesh_pkg::emesh_datamode_t emesh_datamode_in,
   input  emesh_pkg::emesh_ctrlmode_t emesh_ctrlmode_in,
   input  emesh_pkg::emesh_addr_t     emesh_dstaddr_in,
   input  emesh_pkg::emesh_data_t     emesh_data_in,
   input  emesh_pkg::emesh_addr_t     emesh_srcaddr_in,
   // Outgoing packet, rd_clk domain
   output logic                       emesh_access_out,
   output logic                       emesh_write_out,
   output emesh_pkg::emesh_datamode_t emesh_datamode_out,
   output emesh_pkg::emesh_ctrlmode_t emesh_ctrlmode_out,
   output emesh_pkg::emesh_addr_t     emesh_dstaddr_out,
   output emesh_pkg::emesh_data_t     emesh_data_out,
   output emesh_pkg::emesh_addr_t     emesh_srcaddr_out,
   // Consumer pop and sender status
   input  logic                       fifo_read,
   output logic                       fifo_full,
   output logic                       fifo_progfull
);

   emesh_pkg::emesh_packet_t wr_packet;
   emesh_pkg::emesh_packet_t rd_packet;
   logic                     fifo_empty;

   // Pack input fields, access stays out
   assign wr_packet = '{
      srcaddr  : emesh_srcaddr_in,
      data     : emesh_data_in,
      dstaddr  : emesh_dstaddr_in,
      ctrlmode : emesh_ctrlmode_in,
      datamode : emesh_datamode_in,
      write    : emesh_write_in
   };

   // Valid whenever something is queued
   assign emesh_access_out   = ~fifo_empty;
   assign emesh_write_out    = rd_packet.write;
   assign emesh_datamode_out = rd_packet.datamode;
   assign emesh_ctrlmode_out = rd_packet.ctrlmode;
   assign emesh_dstaddr_out  = rd_packet.dstaddr;
   assign emesh_data_out     = rd_packet.data;
   assign emesh_srcaddr_out  = rd_packet.srcaddr;

   fifo_async #(
      .AW              (AW),
      .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
   ) u_fifo (
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .rst_n     (rst_n),
      .wr_en     (emesh_access_in),
      .wr_data   (wr_packet),
      .full      (fifo_full),
      .prog_full (fifo_progfull),
      .rd_en     (fifo_read),
      .rd_data   (rd_packet),
      .empty     (fifo_empty)
   );

endmodule

/* testbench/tb_fifo_async_emesh.sv */
// Emesh clock crossing testbench
module tb_fifo_async_emesh;

   localparam int DEPTH         = 2 ** emesh_pkg::FIFO_AW_DEFAULT;
   localparam int PROG_LEVEL    = emesh_pkg::PROG_FULL_DEFAULT;
   // Lowest queued count at which full may show
   localparam int FULL_FLOOR    = 24;
   localparam int WAIT_LIMIT    = 200;
   localparam int RANDOM_CYCLES = 400;
   // Read edges for an accepted write to show
   localparam int VISIBLE_EDGES = 4;

   logic wr_clk;
   logic rd_clk;
   logic rst_n;

   // Write side stimulus
   logic                     access_in;
   emesh_pkg::emesh_packet_t send_pkt;

   // Read side
   logic                       fifo_read;
   logic                       access_out;
   logic                       write_out;
   emesh_pkg::emesh_datamode_t datamode_out;
   emesh_pkg::emesh_ctrlmode_t ctrlmode_out;
   emesh_pkg::emesh_addr_t     dstaddr_out;
   emesh_pkg::emesh_data_t     data_out;
   emesh_pkg::emesh_addr_t     srcaddr_out;
   emesh_pkg::emesh_packet_t   recv_pkt;
   logic                       fifo_full;
   logic                       fifo_progfull;

   // Reference model, pushed on wr_clk, popped on rd_clk
   emesh_pkg::emesh_packet_t ref_q[$];
   int   push_total  = 0;
   int   pop_total   = 0;
   int   ref_count;
   logic writes_seen = 1'b0;
   logic checks_on;

   // Edge counters for the status flag checks
   int full_wait   = 0;
   int prog_streak = 0;

   logic [31:0] lfsr_state;

   assign ref_count = push_total - pop_total;

   // Output fields packed back for comparison
   assign recv_pkt = '{
      srcaddr  : srcaddr_out,
      data     : data_out,
      dstaddr  : dstaddr_out,
      ctrlmode : ctrlmode_out,
      datamode : datamode_out,
      write    : write_out
   };

   fifo_async_emesh UUT (
      .wr_clk             (wr_clk),
      .rd_clk             (rd_clk),
      .rst_n              (rst_n),
      .emesh_access_in    (access_in),
      .emesh_write_in     (send_pkt.write),
      .emesh_datamode_in  (send_pkt.datamode),
      .emesh_ctrlmode_in  (send_pkt.ctrlmode),
      .emesh_dstaddr_in   (send_pkt.dstaddr),
      .emesh_data_in      (send_pkt.data),
      .emesh_srcaddr_in   (send_pkt.srcaddr),
      .emesh_access_out   (access_out),
      .emesh_write_out    (write_out),
      .emesh_datamode_out (datamode_out),
      .emesh_ctrlmode_out (ctrlmode_out),
      .emesh_dstaddr_out  (dstaddr_out),
      .emesh_data_out     (data_out),
      .emesh_srcaddr_out  (srcaddr_out),
      .fifo_read          (fifo_read),
      .fifo_full          (fifo_full),
      .fifo_progfull      (fifo_progfull)
   );

   // Write clock
   initial begin
      wr_clk = 1'b0;
      forever #10 wr_clk = ~wr_clk;
   end

   // Read clock, 7 units behind
   initial begin
      rd_clk = 1'b0;
      #7;
      forever #10 rd_clk = ~rd_clk;
   end

   task automatic stop_with_failure(input string line);
      $display("%s", line);
      $display("=== FAIL ===");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_mismatch(input string msg);
      stop_with_failure($sformatf("Mismatch at time %0t: %s", $time, msg));
   endtask

   // Galois LFSR, shift right
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'hB4BCD35C;
      end
      return n;
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < count; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   task automatic randomize_packet();
      send_pkt.srcaddr  = take_bits(32);
      send_pkt.data     = take_bits(32);
      send_pkt.dstaddr  = take_bits(32);
      send_pkt.ctrlmode = emesh_pkg::emesh_ctrlmode_t'(take_bits(4));
      send_pkt.datamode = emesh_pkg::emesh_datamode_t'(take_bits(2));
      send_pkt.write    = take_bits(1) != 32'd0;
   endtask

   // Inputs move 2 units after their own edge
   task automatic write_cycle(input logic access);
      @(posedge wr_clk);
      #2;
      randomize_packet();
      access_in = access;
   endtask

   task automatic read_cycle(input logic rd);
      @(posedge rd_clk);
      #2;
      fifo_read = rd;
   endtask

   // Model push, same rule as the write controller
   always @(posedge wr_clk) begin
      // Counters first, from pre-edge values
      full_wait   <= (ref_count >= DEPTH && fifo_full !== 1'b1) ? full_wait + 1 : 0;
      prog_streak <= (ref_count >= PROG_LEVEL) ? prog_streak + 1 : 0;
      if (access_in === 1'b1 && fifo_full === 1'b0) begin
         ref_q.push_back(send_pkt);
         push_total++;
         writes_seen = 1'b1;
      end
   end

   // Model pop and head compare
   always @(posedge rd_clk) begin
      if (checks_on && access_out === 1'b1 && fifo_read === 1'b1) begin
         a_pop_has_ref : assert (ref_q.size() != 0)
            else stop_with_failure("FIFO presented a packet that was never accepted");
         a_head_order : assert (recv_pkt === ref_q[0])
            else report_mismatch($sformatf("packet %0d expected %h got %h",
                                           pop_total, ref_q[0], recv_pkt));
         void'(ref_q.pop_front());
         pop_total++;
      end
   end

   // Quiet status until something is written
   a_quiet_wr : assert property (@(posedge wr_clk) disable iff (!checks_on)
      !writes_seen |-> (!fifo_full && !fifo_progfull)
   ) else report_mismatch("fifo_full or fifo_progfull high before the first write");

   a_quiet_rd : assert property (@(posedge rd_clk) disable iff (!checks_on)
      !writes_seen |-> !access_out
   ) else report_mismatch("emesh_access_out high before the first write");

   // Pessimistic full, but never far off
   a_full_floor : assert property (@(posedge wr_clk) disable iff (!checks_on)
      fifo_full |-> (ref_count >= FULL_FLOOR)
   ) else report_mismatch($sformatf("fifo_full high with %0d queued", ref_count));

   a_full_rises : assert property (@(posedge wr_clk) disable iff (!checks_on)
      full_wait < 4
   ) else report_mismatch("fifo_full late after the FIFO filled");

   a_progfull_follows : assert property (@(posedge wr_clk) disable iff (!checks_on)
      (prog_streak >= 4) |-> fifo_progfull
   ) else report_mismatch($sformatf("fifo_progfull low with %0d queued", ref_count));

   // Write until full, then a few dropped writes
   task automatic fill_burst();
      int waited;
      waited = 0;
      while (fifo_full !== 1'b1) begin
         if (waited >= WAIT_LIMIT) begin
            stop_with_failure("Timed out waiting for fifo_full in the fill burst");
         end else begin
            write_cycle(1'b1);
            waited++;
         end
      end
      repeat (6) write_cycle(1'b1);
      write_cycle(1'b0);
   endtask

   // Read until emesh_access_out stays low over the visibility window
   task automatic drain(output int popped);
      int waited;
      int start;
      int idle;
      waited = 0;
      idle   = 0;
      start  = pop_total;
      while (idle < VISIBLE_EDGES) begin
         if (waited >= WAIT_LIMIT) begin
            stop_with_failure("Timed out waiting for the FIFO to drain");
         end else begin
            read_cycle(1'b1);
            idle = (access_out === 1'b0) ? idle + 1 : 0;
            waited++;
         end
      end
      read_cycle(1'b0);
      popped = pop_total - start;
   endtask

   // Heavy writes first half, light writes second half
   task automatic random_writes(input int cycles);
      logic [31:0] pick;
      for (int i = 0; i < cycles; i++) begin
         @(posedge wr_clk);
         #2;
         pick = take_bits(2);
         if (i < cycles / 2) begin
            access_in = (pick[1:0] != 2'b00);
         end else begin
            access_in = (pick[1:0] == 2'b00);
         end
         randomize_packet();
      end
      write_cycle(1'b0);
   endtask

   task automatic random_reads(input int cycles);
      logic [31:0] pick;
      repeat (cycles) begin
         @(posedge rd_clk);
         #2;
         pick      = take_bits(1);
         fifo_read = pick[0];
      end
      read_cycle(1'b0);
   endtask

   initial begin
      int drained;
      int pops_before;
      checks_on  = 1'b0;
      lfsr_state = 32'h62f1bfa6;
      rst_n      = 1'b0;
      access_in  = 1'b0;
      fifo_read  = 1'b0;
      send_pkt   = '0;

      // Reset phase
      repeat (10) @(posedge wr_clk);
      #2;
      rst_n     = 1'b1;
      checks_on = 1'b1;

      // Pops on an empty FIFO are ignored
      repeat (8) read_cycle(1'b1);
      read_cycle(1'b0);
      a_idle_empty : assert (pop_total == 0 && access_out === 1'b0)
         else stop_with_failure("Read on the empty FIFO after reset was taken");

      // Fill burst, no reads
      fill_burst();
      a_fill_count : assert (push_total == DEPTH)
         else report_mismatch($sformatf("accepted %0d writes in fill", push_total));

      // Drain with continuous reads
      drain(drained);
      a_drain_count : assert (drained == DEPTH)
         else report_mismatch($sformatf("drained %0d, expected %0d", drained, DEPTH));

      // Random traffic in both domains
      fork
         random_writes(RANDOM_CYCLES);
         random_reads(RANDOM_CYCLES);
      join

      // Final drain
      drain(drained);
      a_final_empty : assert (ref_q.size() == 0)
         else report_mismatch($sformatf("%0d packets left after final drain",
                                        ref_q.size()));

      // Reads after the drain change nothing
      pops_before = pop_total;
      repeat (8) read_cycle(1'b1);
      read_cycle(1'b0);
      a_stays_empty : assert (pop_total == pops_before && access_out === 1'b0)
         else report_mismatch("emesh_access_out or pops changed on an empty FIFO");

      $display("=== PASS ===");
      $finish;
   end

endmodule

/* sim.f */
design/emesh_pkg.sv
design/fifo_mem.sv
design/fifo_wr_ctrl.sv
design/fifo_rd_ctrl.sv
design/fifo_async.sv
design/fifo_async_emesh.sv
testbench/tb_fifo_async_emesh.sv

/* Bender.yml */
package:
  name: fifo_async_emesh

sources:
  # Design, in compile order
  - files:
      - design/emesh_pkg.sv
      - design/fifo_mem.sv
      - design/fifo_wr_ctrl.sv
      - design/fifo_rd_ctrl.sv
      - design/fifo_async.sv
      - design/fifo_async_emesh.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_fifo_async_emesh.sv
